// File: project.f
+incdir+rtl
rtl/ex_pkg.sv
rtl/operand_select.sv
rtl/alu.sv
rtl/fpu.sv
rtl/execute_stage.sv
verification/ex_ref_model.sv
verification/tb_execute_stage.sv

// File: Bender.yml
package:
  name: execute_stage

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ex_pkg.sv
      - rtl/operand_select.sv
      - rtl/alu.sv
      - rtl/fpu.sv
      - rtl/execute_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/ex_ref_model.sv
      - verification/tb_execute_stage.sv

// File: verification/tb_execute_stage.sv
`timescale 1ns/10ps
`include "ex_params.svh"

module tb_execute_stage;
	import ex_pkg::*;

	localparam int WAIT_LIMIT = `EX_FPU_MAX_CYCLES + 10;

	typedef struct packed {
		ex_resp_t resp;
		logic float_path;
		logic [63:0] accepted_at;
	} expect_t;

	logic CLK;
	logic reset;
	logic in_valid;
	ex_req_t req;
	logic busy;
	logic out_valid;
	ex_resp_t resp;
	ex_resp_t model_resp;
	logic model_float;
	logic busy_before;
	logic hung = 1'b0;
	string hang_reason;
	int checks;
	int errors;
	expect_t expect_q[$];

	execute_stage UUT (
		.CLK(CLK),
		.reset(reset),
		.in_valid(in_valid),
		.req(req),
		.busy(busy),
		.out_valid(out_valid),
		.resp(resp)
	);

	ex_ref_model u_model (
		.req(req),
		.exp_resp(model_resp),
		.exp_float(model_float)
	);

	always #10 CLK = ~CLK;

	task automatic check_field(input string name, input logic [63:0] got,
			input logic [63:0] want);
		checks++;
		assert (got === want)
		else begin
			errors++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic report_hang(input string why);
		hang_reason = why;
		hung = 1'b1;
	endtask

	initial begin
		wait (hung === 1'b1);
		$display("timeout: %s", hang_reason);
		$display("Test failed");
		$finish;
	end

	// compare every result against the oldest outstanding request.
	always @(negedge CLK) begin
		expect_t e;
		if (!reset && out_valid) begin
			checks++;
			assert (expect_q.size() != 0)
			else begin
				errors++;
				$display("out_valid was high at %0t ns with no request outstanding", $time);
			end
			if (expect_q.size() != 0) begin
				e = expect_q.pop_front();
				check_field("resp.result", resp.result, e.resp.result);
				check_field("resp.dest", resp.dest, e.resp.dest);
				check_field("resp.branch_target", resp.branch_target, e.resp.branch_target);
				check_field("resp.store_data", resp.store_data, e.resp.store_data);
				check_field("resp.pc", resp.pc, e.resp.pc);
				check_field("resp.pc1", resp.pc1, e.resp.pc1);
				check_field("resp.ctrl", resp.ctrl, e.resp.ctrl);
				if (e.float_path) begin
					check_field("busy", busy, 1'b0);
					check_field("busy before out_valid", busy_before, 1'b1);
				end else begin
					check_field("out_valid time", $time, e.accepted_at + 64'd30);
				end
			end
		end
		busy_before = busy;
	end

	function automatic ex_ctrl_t random_ctrl();
		ex_ctrl_t c;
		c.reg_write = $urandom_range(1);
		c.mem_to_reg = $urandom_range(3);
		c.branch = $urandom_range(3);
		c.mem_write = 1'b0;
		c.mem_read = 1'b0;
		c.uart_to_reg = $urandom_range(1);
		c.inst_index = 26'($urandom);
		return c;
	endfunction

	function automatic ex_req_t random_req(input logic any_select);
		ex_req_t r;
		logic shift;
		r.alu_op = alu_op_e'($urandom_range(11));
		r.is_float = 1'b0;
		r.op1_reg = $urandom;
		r.op2_reg = $urandom;
		r.rt = 5'($urandom);
		r.rd = 5'($urandom);
		r.sa = 5'($urandom);
		r.immediate = 16'($urandom);
		r.pc = $urandom_range((1 << `EX_PC_WIDTH) - 1);
		r.pc1 = $urandom_range((1 << `EX_PC_WIDTH) - 1);
		if (any_select) begin
			r.op1_src = op1_src_e'($urandom_range(1));
			r.op2_src = op2_src_e'($urandom_range(3));
			r.dest_sel = dest_sel_e'($urandom_range(2));
		end else begin
			shift = r.alu_op inside {alu_sll, alu_srl, alu_sra}; // shifts move rt by sa.
			r.op1_src = shift ? op1_from_op2 : op1_from_op1;
			r.op2_src = shift ? op2_from_sa : op2_from_reg;
			r.dest_sel = dest_rd;
		end
		r.ctrl = random_ctrl();
		return r;
	endfunction

	function automatic logic [31:0] random_float(input int lo, input int hi);
		logic [31:0] f;
		f[31] = $urandom_range(1);
		f[30:23] = $urandom_range(hi, lo);
		f[22:0] = 23'($urandom);
		return f;
	endfunction

	function automatic ex_req_t random_float_req(input logic mem_access);
		ex_req_t r;
		logic [31:0] v;
		r = random_req(1'b0);
		r.alu_op = alu_op_e'(12 + $urandom_range(2));
		r.is_float = 1'b1;
		r.op1_src = op1_from_op1;
		r.op2_src = op2_from_reg;
		r.dest_sel = dest_sel_e'($urandom_range(2));
		case (r.alu_op)
			alu_fmul: begin
				r.op1_reg = ($urandom_range(3) == 0) ? random_float(0, 255) : random_float(100, 154);
				r.op2_reg = ($urandom_range(3) == 0) ? random_float(0, 255) : random_float(100, 154);
			end
			alu_fcvt_ws:
				r.op1_reg = random_float(110, 165); // reaches past the saturation point.
			default: begin
				v = $urandom >> $urandom_range(31);
				if ($urandom_range(1) == 1)
					v = -v;
				r.op1_reg = ($urandom_range(7) == 0) ? 32'd0 : v;
			end
		endcase
		if (mem_access) begin
			r.ctrl.mem_read = $urandom_range(1);
			r.ctrl.mem_write = !r.ctrl.mem_read;
		end
		return r;
	endfunction

	// called just after a falling edge and returns just after one.
	task automatic send_req(input ex_req_t r);
		expect_t e;
		int waited;
		req = r;
		in_valid = 1'b1;
		waited = 0;
		while (busy) begin
			@(negedge CLK);
			waited++;
			if (waited == WAIT_LIMIT)
				report_hang("stage stayed busy before a new request");
		end
		@(posedge CLK);
		e.resp = model_resp;
		e.float_path = model_float;
		e.accepted_at = $time;
		expect_q.push_back(e);
		@(negedge CLK);
		waited = 0;
		while (busy) begin
			@(negedge CLK); // decode holds the request until busy drops.
			waited++;
			if (waited == WAIT_LIMIT)
				report_hang("float request did not finish");
		end
	endtask

	task automatic drain();
		int waited;
		in_valid = 1'b0;
		waited = 0;
		do begin
			@(posedge CLK);
			waited++;
			if (waited == WAIT_LIMIT)
				report_hang("results still outstanding after the last request");
		end while (expect_q.size() != 0);
		@(negedge CLK);
	endtask

	task automatic run_test(input int number, input string name, input int count,
			input int mode);
		int errors_before;
		ex_req_t r;
		errors_before = errors;
		for (int i = 0; i < count; i++) begin
			case (mode)
				0: r = random_req(1'b0);
				1: r = random_req(1'b1);
				2: r = random_float_req(1'b0);
				3: r = random_float_req(1'b1);
				default: r = (i % 2 == 0) ? random_float_req(1'b0) : random_req(1'b1);
			endcase
			send_req(r);
		end
		drain();
		$display("test %0d %s: %0d requests, %0d errors", number, name, count,
			errors - errors_before);
	endtask

	initial begin
		CLK = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		req = '0;
		checks = 0;
		errors = 0;
		void'($urandom(32'h1d62));
		repeat (4) @(negedge CLK);
		reset = 1'b0;
		check_field("out_valid", out_valid, 1'b0);
		check_field("busy", busy, 1'b0);
		check_field("resp.ctrl.branch", resp.ctrl.branch, 2'b11);
		$display("test 1 reset state: %0d errors", errors);
		run_test(2, "integer alu", 300, 0);
		run_test(3, "operand and destination select", 200, 1);
		run_test(4, "float path", 100, 2);
		run_test(5, "memory access override", 50, 3);
		run_test(6, "pass-through", 100, 4);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: verification/ex_ref_model.sv
`timescale 1ns/10ps
`include "ex_params.svh"

module ex_ref_model (
	input ex_pkg::ex_req_t req,
	output ex_pkg::ex_resp_t exp_resp,
	output logic exp_float
);
	import ex_pkg::*;

	logic [31:0] a;
	logic [31:0] b;

	function automatic logic [31:0] int_op(input alu_op_e op, input logic [31:0] x,
			input logic [31:0] y);
		case (op)
			alu_add: return x + y;
			alu_sub: return x - y;
			alu_and: return x & y;
			alu_or: return x | y;
			alu_xor: return x ^ y;
			alu_nor: return ~(x | y);
			alu_slt: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			alu_sltu: return (x < y) ? 32'd1 : 32'd0;
			alu_sll: return x << y[4:0];
			alu_srl: return x >> y[4:0];
			alu_sra: return $signed(x) >>> y[4:0];
			alu_lui: return y << 16;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] fmul_rz(input logic [31:0] x, input logic [31:0] y);
		logic sign;
		logic [47:0] prod;
		logic [22:0] frac;
		integer e;
		sign = x[31] ^ y[31];
		if (x[30:23] == 8'd0 || y[30:23] == 8'd0)
			return {sign, 31'd0};
		prod = {1'b1, x[22:0]} * {1'b1, y[22:0]};
		e = int'(x[30:23]) + int'(y[30:23]) - 127;
		frac = prod[45:23];
		if (prod[47]) begin
			e = e + 1; // product reached [2,4), so the point moves one place.
			frac = prod[46:24];
		end
		if (e <= 0)
			return {sign, 31'd0};
		if (e >= 255)
			return {sign, 8'hff, 23'd0};
		return {sign, e[7:0], frac};
	endfunction

	function automatic logic [31:0] int_to_float(input logic [31:0] x);
		logic [31:0] mag;
		logic [31:0] norm;
		integer msb;
		if (x == 32'd0)
			return 32'd0;
		mag = x[31] ? -x : x;
		msb = 0;
		for (int i = 0; i < 32; i++)
			if (mag[i])
				msb = i;
		norm = mag << (31 - msb);
		return {x[31], 8'(127 + msb), norm[30:8]}; // bits below the mantissa are dropped.
	endfunction

	function automatic logic [31:0] float_to_int(input logic [31:0] x);
		logic [31:0] mag;
		integer e;
		e = int'(x[30:23]) - 127;
		if (e > 30)
			return x[31] ? 32'h8000_0000 : 32'h7fff_ffff;
		if (e < 0)
			return 32'd0;
		mag = {8'd0, 1'b1, x[22:0]};
		mag = (e >= 23) ? mag << (e - 23) : mag >> (23 - e);
		return x[31] ? -mag : mag;
	endfunction

	always_comb begin
		a = (req.op1_src == op1_from_op2) ? req.op2_reg : req.op1_reg;
		case (req.op2_src)
			op2_from_sa: b = {27'd0, req.sa};
			op2_from_simm: b = {{16{req.immediate[15]}}, req.immediate};
			op2_from_zimm: b = {16'd0, req.immediate};
			default: b = req.op2_reg;
		endcase
		exp_float = req.is_float && !req.ctrl.mem_read && !req.ctrl.mem_write;
		case (req.dest_sel)
			dest_rt: exp_resp.dest = req.rt;
			dest_link: exp_resp.dest = 5'd31;
			default: exp_resp.dest = req.rd;
		endcase
		exp_resp.store_data = req.op2_reg;
		exp_resp.branch_target = req.pc + req.immediate[`EX_PC_WIDTH-1:0];
		exp_resp.pc = req.pc;
		exp_resp.pc1 = req.pc1;
		exp_resp.ctrl = req.ctrl;
		if (!exp_float)
			exp_resp.result = int_op(req.is_float ? alu_add : req.alu_op, a, b);
		else if (req.alu_op == alu_fmul)
			exp_resp.result = fmul_rz(a, b);
		else if (req.alu_op == alu_fcvt_sw)
			exp_resp.result = int_to_float(a);
		else if (req.alu_op == alu_fcvt_ws)
			exp_resp.result = float_to_int(a);
		else
			exp_resp.result = 32'd0;
	end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/10ps
`include "ex_params.svh"

module execute_stage (
	input logic CLK,
	input logic reset,
	input logic in_valid,
	input ex_pkg::ex_req_t req,
	output logic busy,
	output logic out_valid,
	output ex_pkg::ex_resp_t resp
);
	import ex_pkg::*;

	typedef enum logic {st_idle, st_wait_fpu} stage_state_e;

	stage_state_e state;
	ex_req_t req_q;
	logic issue_int;
	logic accept;
	logic accept_float;
	logic result_ready;
	logic fpu_start;
	logic fpu_done;
	logic [`EX_DATA_WIDTH-1:0] fpu_result;
	logic [`EX_DATA_WIDTH-1:0] alu_result;
	logic [`EX_DATA_WIDTH-1:0] op1;
	logic [`EX_DATA_WIDTH-1:0] op2;
	logic [4:0] dest;
	alu_op_e alu_op_int;
	logic [`EX_PC_WIDTH-1:0] branch_target;

	assign busy = (state == st_wait_fpu);
	assign accept = in_valid && !busy;
	// loads and stores compute their address on the alu even when flagged float.
	assign accept_float = req.is_float && !(req.ctrl.mem_read || req.ctrl.mem_write);
	assign alu_op_int = req_q.is_float ? alu_add : req_q.alu_op;
	assign branch_target = req_q.pc + req_q.immediate[`EX_PC_WIDTH-1:0];
	assign result_ready = issue_int || (busy && fpu_done);

	operand_select u_operand_select (
		.req(req_q),
		.op1(op1),
		.op2(op2),
		.dest(dest)
	);

	alu u_alu (
		.op(alu_op_int),
		.a(op1),
		.b(op2),
		.result(alu_result)
	);

	fpu u_fpu (
		.CLK(CLK),
		.reset(reset),
		.start(fpu_start),
		.op(req_q.alu_op),
		.a(op1),
		.b(op2),
		.result(fpu_result),
		.done(fpu_done)
	);

	always_ff @(posedge CLK) begin
		if (accept)
			req_q <= req;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= st_idle;
			issue_int <= 1'b0;
			fpu_start <= 1'b0;
		end else begin
			issue_int <= accept && !accept_float;
			fpu_start <= accept && accept_float; // busy holds off a second accept so this stays a single pulse.
			case (state)
				st_idle:
					if (accept && accept_float)
						state <= st_wait_fpu;
				st_wait_fpu:
					if (fpu_done)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			out_valid <= 1'b0;
			resp.ctrl <= '{branch: 2'b11, default: '0};
		end else begin
			out_valid <= result_ready;
			if (result_ready) begin
				resp.result <= issue_int ? alu_result : fpu_result;
				resp.store_data <= req_q.op2_reg;
				resp.dest <= dest;
				resp.branch_target <= branch_target;
				resp.pc <= req_q.pc;
				resp.pc1 <= req_q.pc1;
				resp.ctrl <= req_q.ctrl;
			end
		end
	end

	assert property (@(posedge CLK) disable iff (reset)
		accept |-> ##[2:(`EX_FPU_MAX_CYCLES + 2)] out_valid)
		else $error("accepted request never produced out_valid");

	assert property (@(posedge CLK) disable iff (reset) busy |-> in_valid && $stable(req))
		else $error("request changed while the stage was busy");

	assert property (@(posedge CLK) disable iff (reset) fpu_done |-> busy)
		else $error("fpu done arrived while the stage was not waiting for it");

endmodule

// File: rtl/fpu.sv
`timescale 1ns/10ps
`include "ex_params.svh"

module fpu (
	input logic CLK,
	input logic reset,
	input logic start,
	input ex_pkg::alu_op_e op,
	input logic [`EX_DATA_WIDTH-1:0] a,
	input logic [`EX_DATA_WIDTH-1:0] b,
	output logic [`EX_DATA_WIDTH-1:0] result,
	output logic done
);
	import ex_pkg::*;

	typedef enum logic [1:0] {fpu_idle, fpu_multiply, fpu_normalize, fpu_finish} fpu_state_e;

	fpu_state_e state;
	alu_op_e op_q;
	logic sign_q;
	logic signed [9:0] exp_q; // unbiased for fcvt_ws, biased otherwise.
	logic [47:0] acc;
	logic [47:0] mcand;
	logic [23:0] mplier;
	logic [4:0] cnt;
	logic signed [9:0] mul_exp;
	logic [22:0] mul_mant;

	function automatic logic [31:0] pack_mul(input logic sign, input logic signed [9:0] exp,
			input logic [22:0] mant);
		if (exp <= 10'sd0)
			return {sign, 31'd0};
		else if (exp >= 10'sd255)
			return {sign, 8'hff, 23'd0};
		else
			return {sign, exp[7:0], mant};
	endfunction

	assign mul_exp = acc[47] ? exp_q + 10'sd1 : exp_q; // product of two 1.x lies in [1,4).
	assign mul_mant = acc[47] ? acc[46:24] : acc[45:23];

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= fpu_idle;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				fpu_idle: begin
					if (start) begin
						op_q <= op;
						sign_q <= a[31];
						state <= fpu_finish;
						done <= 1'b1;
						result <= '0;
						case (op)
							alu_fmul: begin
								sign_q <= a[31] ^ b[31];
								exp_q <= $signed({2'b00, a[30:23]}) + $signed({2'b00, b[30:23]}) - 10'sd127;
								acc <= '0;
								mcand <= {24'd0, 1'b1, a[22:0]};
								mplier <= {1'b1, b[22:0]};
								cnt <= 5'd23;
								if (a[30:23] == 8'd0 || b[30:23] == 8'd0) begin
									result <= {a[31] ^ b[31], 31'd0}; // denormals flush to zero.
								end else begin
									state <= fpu_multiply;
									done <= 1'b0;
								end
							end
							alu_fcvt_sw: begin
								acc <= {16'd0, a[31] ? -a : a};
								exp_q <= 10'sd158;
								if (a != '0) begin
									state <= fpu_normalize;
									done <= 1'b0;
								end
							end
							alu_fcvt_ws: begin
								acc <= {24'd0, 1'b1, a[22:0]};
								exp_q <= $signed({2'b00, a[30:23]}) - 10'sd127;
								if (a[30:23] > 8'd157) begin
									result <= a[31] ? 32'h8000_0000 : 32'h7fff_ffff;
								end else if (a[30:23] >= 8'd127) begin
									state <= fpu_normalize;
									done <= 1'b0;
								end
							end
							default: ;
						endcase
					end
				end
				fpu_multiply: begin
					if (mplier[0])
						acc <= acc + mcand;
					mcand <= mcand << 1;
					mplier <= mplier >> 1;
					cnt <= cnt - 5'd1;
					if (cnt == 5'd0)
						state <= fpu_normalize;
				end
				fpu_normalize: begin
					case (op_q)
						alu_fmul: begin
							result <= pack_mul(sign_q, mul_exp, mul_mant);
							state <= fpu_finish;
							done <= 1'b1;
						end
						alu_fcvt_sw: begin
							if (acc[31]) begin
								result <= {sign_q, exp_q[7:0], acc[30:8]}; // low bits drop.
								state <= fpu_finish;
								done <= 1'b1;
							end else begin
								acc <= acc << 1;
								exp_q <= exp_q - 10'sd1;
							end
						end
						default: begin
							if (exp_q == 10'sd23) begin
								result <= sign_q ? -acc[31:0] : acc[31:0];
								state <= fpu_finish;
								done <= 1'b1;
							end else if (exp_q < 10'sd23) begin
								acc <= acc >> 1;
								exp_q <= exp_q + 10'sd1;
							end else begin
								acc <= acc << 1;
								exp_q <= exp_q - 10'sd1;
							end
						end
					endcase
				end
				default:
					state <= fpu_idle;
			endcase
		end
	end

	assert property (@(posedge CLK) disable iff (reset) done |-> state != fpu_idle)
		else $error("fpu done raised while idle");

	assert property (@(posedge CLK) disable iff (reset) start |-> state == fpu_idle)
		else $error("fpu started while an operation is running");

	assert property (@(posedge CLK) disable iff (reset)
		start |-> ##[1:`EX_FPU_MAX_CYCLES] done)
		else $error("fpu latency exceeded its bound");

endmodule

// File: rtl/alu.sv
`timescale 1ns/10ps
`include "ex_params.svh"

module alu (
	input ex_pkg::alu_op_e op,
	input logic [`EX_DATA_WIDTH-1:0] a,
	input logic [`EX_DATA_WIDTH-1:0] b,
	output logic [`EX_DATA_WIDTH-1:0] result
);
	import ex_pkg::*;

	logic [4:0] shamt;
	logic less_signed;
	logic less_unsigned;

	assign shamt = b[4:0];
	assign less_signed = $signed(a) < $signed(b);
	assign less_unsigned = a < b;

	always_comb begin
		case (op)
			alu_add:
				result = a + b;
			alu_sub:
				result = a - b;
			alu_and:
				result = a & b;
			alu_or:
				result = a | b;
			alu_xor:
				result = a ^ b;
			alu_nor:
				result = ~(a | b);
			alu_slt:
				result = {{(`EX_DATA_WIDTH-1){1'b0}}, less_signed};
			alu_sltu:
				result = {{(`EX_DATA_WIDTH-1){1'b0}}, less_unsigned};
			alu_sll:
				result = a << shamt;
			alu_srl:
				result = a >> shamt;
			alu_sra:
				result = $signed(a) >>> shamt; // sign bit fills from the left.
			alu_lui:
				result = {b[15:0], 16'd0};
			default:
				result = '0; // float opcodes are the fpu's job.
		endcase
	end

endmodule

// File: rtl/operand_select.sv
`timescale 1ns/10ps
`include "ex_params.svh"

module operand_select (
	input ex_pkg::ex_req_t req,
	output logic [`EX_DATA_WIDTH-1:0] op1,
	output logic [`EX_DATA_WIDTH-1:0] op2,
	output logic [4:0] dest
);
	import ex_pkg::*;

	always_comb begin
		case (req.op1_src)
			op1_from_op2: op1 = req.op2_reg; // shifts take rt as the value.
			default: op1 = req.op1_reg;
		endcase
	end

	always_comb begin
		case (req.op2_src)
			op2_from_sa: op2 = {{(`EX_DATA_WIDTH-5){1'b0}}, req.sa};
			op2_from_simm: op2 = {{(`EX_DATA_WIDTH-16){req.immediate[15]}}, req.immediate};
			op2_from_zimm: op2 = {{(`EX_DATA_WIDTH-16){1'b0}}, req.immediate};
			default: op2 = req.op2_reg;
		endcase
	end

	always_comb begin
		case (req.dest_sel)
			dest_rt: dest = req.rt;
			dest_link: dest = 5'd31; // link register for jal.
			default: dest = req.rd;
		endcase
	end

endmodule

// File: rtl/ex_pkg.sv
`include "ex_params.svh"

package ex_pkg;

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or = 4'd3,
		alu_xor = 4'd4,
		alu_nor = 4'd5,
		alu_slt = 4'd6,
		alu_sltu = 4'd7,
		alu_sll = 4'd8,
		alu_srl = 4'd9,
		alu_sra = 4'd10,
		alu_lui = 4'd11,
		alu_fmul = 4'd12,
		alu_fcvt_sw = 4'd13,
		alu_fcvt_ws = 4'd14
	} alu_op_e;

	typedef enum logic {op1_from_op1, op1_from_op2} op1_src_e; // op2 feeds shifts.

	typedef enum logic [1:0] {op2_from_reg, op2_from_sa, op2_from_simm, op2_from_zimm} op2_src_e;

	typedef enum logic [1:0] {dest_rd, dest_rt, dest_link} dest_sel_e;

	typedef struct packed {
		logic reg_write;
		logic [1:0] mem_to_reg;
		logic [1:0] branch; // 2'b11 means no branch.
		logic mem_write;
		logic mem_read;
		logic uart_to_reg;
		logic [25:0] inst_index;
	} ex_ctrl_t;

	typedef struct packed {
		alu_op_e alu_op;
		op1_src_e op1_src;
		op2_src_e op2_src;
		dest_sel_e dest_sel;
		logic is_float;
		logic [`EX_DATA_WIDTH-1:0] op1_reg;
		logic [`EX_DATA_WIDTH-1:0] op2_reg;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		logic [15:0] immediate;
		logic [`EX_PC_WIDTH-1:0] pc;
		logic [`EX_PC_WIDTH-1:0] pc1;
		ex_ctrl_t ctrl;
	} ex_req_t;

	typedef struct packed {
		logic [`EX_DATA_WIDTH-1:0] result;
		logic [`EX_DATA_WIDTH-1:0] store_data;
		logic [4:0] dest;
		logic [`EX_PC_WIDTH-1:0] branch_target;
		logic [`EX_PC_WIDTH-1:0] pc;
		logic [`EX_PC_WIDTH-1:0] pc1;
		ex_ctrl_t ctrl;
	} ex_resp_t;

endpackage

// File: rtl/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// width of the instruction address carried through the stage.
`define EX_PC_WIDTH 8

`define EX_DATA_WIDTH 32

// worst case from fpu start to fpu done, in cycles.
`define EX_FPU_MAX_CYCLES 40

`endif
